// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen       = 64;
    localparam int ilen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_imm_32 = 7'b0011011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_reg_32 = 7'b0111011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [ilen-1:0] inst_ebreak = 32'h0010_0073;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [xlen-1:0] reset_pc = 64'h0;

endpackage

// ==== design/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

    localparam int alu_op_w  = 4;
    localparam int next_pc_w = 2;

    typedef enum logic [alu_op_w-1:0] {
        add,
        sub,
        sll,
        slt,
        sltu,
        xor_op,
        srl,
        sra,
        or_op,
        and_op,
        // compares return 0 or 1
        eq,
        ne,
        lt,
        ge,
        ltu,
        geu
    } alu_op_t;

    typedef enum logic [1:0] {
        rs1,
        pc,
        zero
    } src1_sel_t;

    typedef enum logic [1:0] {
        rs2,
        imm,
        four
    } src2_sel_t;

    typedef enum logic [next_pc_w-1:0] {
        seq,
        branch,
        jal,
        jalr
    } next_pc_t;

    // immediate formats
    localparam logic [2:0] kind_i = 3'd0;
    localparam logic [2:0] kind_s = 3'd1;
    localparam logic [2:0] kind_b = 3'd2;
    localparam logic [2:0] kind_u = 3'd3;
    localparam logic [2:0] kind_j = 3'd4;

endpackage

// ==== design/rv_control.sv ====
`timescale 1ns/1ps

module rv_control (
    input  logic [6:0]               opcode,
    input  logic [2:0]               funct3,
    input  logic [6:0]               funct7,
    output core_ctrl_pkg::alu_op_t   alu_op,
    output core_ctrl_pkg::src1_sel_t src1_sel,
    output core_ctrl_pkg::src2_sel_t src2_sel,
    output core_ctrl_pkg::next_pc_t  next_pc,
    output logic                     word_op,
    output logic                     rf_we,
    output logic [2:0]               imm_kind,
    output logic                     illegal
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    alu_op_t arith_op;
    alu_op_t cmp_op;
    logic    is_reg;
    logic    is_word;
    logic    bad_funct7;
    logic    bad_word_f3;

    assign is_reg  = (opcode == op_reg) || (opcode == op_reg_32);
    assign is_word = (opcode == op_imm_32) || (opcode == op_reg_32);
    // register forms allow only bit 5 of funct7
    assign bad_funct7 = (funct7 & 7'b1011111) != 7'b0;
    // word forms: add/sub and shifts only
    assign bad_word_f3 = !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101);

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (is_reg && funct7[5]) ? sub : add;
            3'b001:  arith_op = sll;
            3'b010:  arith_op = slt;
            3'b011:  arith_op = sltu;
            3'b100:  arith_op = xor_op;
            3'b101:  arith_op = funct7[5] ? sra : srl;
            3'b110:  arith_op = or_op;
            default: arith_op = and_op;
        endcase
    end

    always_comb begin
        case (funct3)
            f3_beq:  cmp_op = eq;
            f3_bne:  cmp_op = ne;
            f3_blt:  cmp_op = lt;
            f3_bge:  cmp_op = ge;
            f3_bltu: cmp_op = ltu;
            default: cmp_op = geu;
        endcase
    end

    always_comb begin
        alu_op   = add;
        src1_sel = rs1;
        src2_sel = rs2;
        next_pc  = seq;
        word_op  = 1'b0;
        rf_we    = 1'b0;
        imm_kind = kind_i;
        illegal  = 1'b0;
        case (opcode)
            op_imm, op_imm_32: begin
                alu_op   = arith_op;
                src2_sel = imm;
                word_op  = is_word;
                illegal  = is_word && bad_word_f3;
                rf_we    = !(is_word && bad_word_f3);
            end
            op_reg, op_reg_32: begin
                alu_op  = arith_op;
                word_op = is_word;
                illegal = bad_funct7 || (is_word && bad_word_f3);
                rf_we   = !(bad_funct7 || (is_word && bad_word_f3));
            end
            op_lui: begin
                src1_sel = zero;
                src2_sel = imm;
                imm_kind = kind_u;
                rf_we    = 1'b1;
            end
            op_auipc: begin
                src1_sel = pc;
                src2_sel = imm;
                imm_kind = kind_u;
                rf_we    = 1'b1;
            end
            // link value is pc + 4, target formed in fetch
            op_jal: begin
                src1_sel = pc;
                src2_sel = four;
                next_pc  = jal;
                imm_kind = kind_j;
                rf_we    = 1'b1;
            end
            op_jalr: begin
                src1_sel = pc;
                src2_sel = four;
                next_pc  = jalr;
                rf_we    = 1'b1;
            end
            op_branch: begin
                alu_op   = cmp_op;
                next_pc  = branch;
                imm_kind = kind_b;
                illegal  = (funct3[2:1] == 2'b01);
            end
            // only ebreak/ecall style encodings, no csr access
            op_system: illegal = (funct3 != 3'b000);
            default:   illegal = 1'b1;
        endcase
    end

endmodule

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic                              clk,
    input  logic                              we,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_isa_pkg::xlen-1:0]       wdata,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_isa_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv_isa_pkg::xlen-1:0]       rdata1,
    output logic [rv_isa_pkg::xlen-1:0]       rdata2
);
    import rv_isa_pkg::*;

    logic [xlen-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        // x0 never written
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
    input  logic                                clk,
    input  logic [rv_isa_pkg::xlen-1:0]         pc,
    input  logic [rv_isa_pkg::ilen-1:0]         inst,
    input  logic [rv_isa_pkg::xlen-1:0]         alu_result,
    input  logic                                rf_we_strobe,
    output logic [core_ctrl_pkg::alu_op_w-1:0]  alu_op,
    output logic                                word_op,
    output logic [core_ctrl_pkg::next_pc_w-1:0] next_pc,
    output logic                                rf_we,
    output logic [rv_isa_pkg::xlen-1:0]         alu_src1,
    output logic [rv_isa_pkg::xlen-1:0]         alu_src2,
    output logic [rv_isa_pkg::xlen-1:0]         rs1_data,
    output logic [rv_isa_pkg::xlen-1:0]         imm,
    output logic                                sys,
    output logic                                illegal
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [reg_addr_w-1:0] rd_idx;
    logic [reg_addr_w-1:0] rs1_idx;
    logic [reg_addr_w-1:0] rs2_idx;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       i_imm;
    logic [xlen-1:0]       s_imm;
    logic [xlen-1:0]       b_imm;
    logic [xlen-1:0]       u_imm;
    logic [xlen-1:0]       j_imm;
    logic [2:0]            imm_kind;
    src1_sel_t             src1_sel;
    src2_sel_t             src2_sel;

    assign rd_idx  = inst[11:7];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];

    assign sys = (inst == inst_ebreak);

    rv_control u_control (
        .opcode   (inst[6:0]),
        .funct3   (inst[14:12]),
        .funct7   (inst[31:25]),
        .alu_op   (alu_op),
        .src1_sel (src1_sel),
        .src2_sel (src2_sel),
        .next_pc  (next_pc),
        .word_op  (word_op),
        .rf_we    (rf_we),
        .imm_kind (imm_kind),
        .illegal  (illegal)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .we     (rf_we_strobe && rf_we),
        .waddr  (rd_idx),
        .wdata  (alu_result),
        .raddr1 (rs1_idx),
        .raddr2 (rs2_idx),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // sign-extended immediates
    assign i_imm = {{52{inst[31]}}, inst[31:20]};
    assign s_imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign j_imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (imm_kind)
            kind_s:  imm = s_imm;
            kind_b:  imm = b_imm;
            kind_u:  imm = u_imm;
            kind_j:  imm = j_imm;
            default: imm = i_imm;
        endcase
    end

    // operand select, zero for lui
    always_comb begin
        case (src1_sel)
            rs1:     alu_src1 = rs1_data;
            zero:    alu_src1 = '0;
            default: alu_src1 = pc;
        endcase
        case (src2_sel)
            rs2:     alu_src2 = rs2_data;
            four:    alu_src2 = xlen'(4);
            default: alu_src2 = imm;
        endcase
    end

endmodule

// ==== design/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  logic [core_ctrl_pkg::alu_op_w-1:0] alu_op,
    input  logic                               word_op,
    input  logic [rv_isa_pkg::xlen-1:0]        src1,
    input  logic [rv_isa_pkg::xlen-1:0]        src2,
    output logic [rv_isa_pkg::xlen-1:0]        result
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [xlen-1:0] full_res;
    logic [31:0]     word_res;

    always_comb begin
        case (alu_op)
            sub:     full_res = src1 - src2;
            sll:     full_res = src1 << src2[5:0];
            slt:     full_res = xlen'($signed(src1) < $signed(src2));
            sltu:    full_res = xlen'(src1 < src2);
            xor_op:  full_res = src1 ^ src2;
            srl:     full_res = src1 >> src2[5:0];
            sra:     full_res = $signed(src1) >>> src2[5:0];
            or_op:   full_res = src1 | src2;
            and_op:  full_res = src1 & src2;
            eq:      full_res = xlen'(src1 == src2);
            ne:      full_res = xlen'(src1 != src2);
            lt:      full_res = xlen'($signed(src1) < $signed(src2));
            ge:      full_res = xlen'($signed(src1) >= $signed(src2));
            ltu:     full_res = xlen'(src1 < src2);
            geu:     full_res = xlen'(src1 >= src2);
            default: full_res = src1 + src2;
        endcase
    end

    // word forms, 5-bit shift amount
    always_comb begin
        case (alu_op)
            sub:     word_res = src1[31:0] - src2[31:0];
            sll:     word_res = src1[31:0] << src2[4:0];
            srl:     word_res = src1[31:0] >> src2[4:0];
            sra:     word_res = $signed(src1[31:0]) >>> src2[4:0];
            default: word_res = src1[31:0] + src2[31:0];
        endcase
    end

    assign result = word_op ? {{32{word_res[31]}}, word_res} : full_res;

endmodule

// ==== design/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                imem_ack,
    input  logic [rv_isa_pkg::ilen-1:0]         imem_rdata,
    input  logic [core_ctrl_pkg::next_pc_w-1:0] next_pc,
    input  logic [rv_isa_pkg::xlen-1:0]         alu_result,
    input  logic [rv_isa_pkg::xlen-1:0]         rs1_data,
    input  logic [rv_isa_pkg::xlen-1:0]         imm,
    input  logic                                sys,
    input  logic                                illegal,
    input  logic                                rf_we,
    output logic                                imem_req,
    output logic [rv_isa_pkg::xlen-1:0]         imem_addr,
    output logic [rv_isa_pkg::xlen-1:0]         pc,
    output logic [rv_isa_pkg::ilen-1:0]         inst,
    output logic                                rf_we_strobe,
    output logic                                retire_valid,
    output logic [rv_isa_pkg::xlen-1:0]         retire_pc,
    output logic [rv_isa_pkg::reg_addr_w-1:0]   retire_rd,
    output logic [rv_isa_pkg::xlen-1:0]         retire_wdata,
    output logic                                retire_we,
    output logic                                halted
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    typedef enum logic [1:0] {
        st_issue,
        st_release,
        st_execute,
        st_halt
    } fetch_state_t;

    fetch_state_t    state;
    logic            capture;
    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] jalr_sum;
    logic [xlen-1:0] pc_next;

    assign capture = (state == st_issue) && imem_req && imem_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_issue;
            imem_req <= 1'b0;
            pc       <= reset_pc;
        end else begin
            case (state)
                st_issue: begin
                    if (capture) begin
                        imem_req <= 1'b0;
                        state    <= st_release;
                    end else begin
                        imem_req <= 1'b1;
                    end
                end
                // wait for the memory to drop ack
                st_release: begin
                    if (!imem_ack) begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    pc <= pc_next;
                    if (sys || illegal) begin
                        state <= st_halt;
                    end else begin
                        state    <= st_issue;
                        imem_req <= 1'b1;
                    end
                end
                default: imem_req <= 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            inst <= imem_rdata;
        end
    end

    assign seq_pc   = pc + xlen'(4);
    assign jalr_sum = rs1_data + imm;

    always_comb begin
        case (next_pc)
            branch:  pc_next = alu_result[0] ? pc + imm : seq_pc;
            jal:     pc_next = pc + imm;
            jalr:    pc_next = {jalr_sum[xlen-1:1], 1'b0};
            default: pc_next = seq_pc;
        endcase
    end

    assign imem_addr    = pc;
    assign rf_we_strobe = (state == st_execute);
    assign halted       = (state == st_halt);

    // retire trace
    assign retire_valid = (state == st_execute);
    assign retire_pc    = pc;
    assign retire_rd    = inst[11:7];
    assign retire_wdata = alu_result;
    assign retire_we    = rf_we && (inst[11:7] != '0);

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              imem_ack,
    input  logic [rv_isa_pkg::ilen-1:0]       imem_rdata,
    output logic                              imem_req,
    output logic [rv_isa_pkg::xlen-1:0]       imem_addr,
    output logic                              retire_valid,
    output logic [rv_isa_pkg::xlen-1:0]       retire_pc,
    output logic [rv_isa_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_isa_pkg::xlen-1:0]       retire_wdata,
    output logic                              retire_we,
    output logic                              halted
);
    import rv_isa_pkg::*;

    logic [xlen-1:0] pc;
    logic [ilen-1:0] inst;
    logic [3:0]      alu_op;
    logic [1:0]      next_pc;
    logic            word_op;
    logic            rf_we;
    logic            rf_we_strobe;
    logic            sys;
    logic            illegal;
    logic [xlen-1:0] alu_src1;
    logic [xlen-1:0] alu_src2;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] alu_result;

    rv_fetch u_fetch (
        .clk          (clk),
        .rst          (rst),
        .imem_ack     (imem_ack),
        .imem_rdata   (imem_rdata),
        .next_pc      (next_pc),
        .alu_result   (alu_result),
        .rs1_data     (rs1_data),
        .imm          (imm),
        .sys          (sys),
        .illegal      (illegal),
        .rf_we        (rf_we),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .pc           (pc),
        .inst         (inst),
        .rf_we_strobe (rf_we_strobe),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .retire_we    (retire_we),
        .halted       (halted)
    );

    rv_decode u_decode (
        .clk          (clk),
        .pc           (pc),
        .inst         (inst),
        .alu_result   (alu_result),
        .rf_we_strobe (rf_we_strobe),
        .alu_op       (alu_op),
        .word_op      (word_op),
        .next_pc      (next_pc),
        .rf_we        (rf_we),
        .alu_src1     (alu_src1),
        .alu_src2     (alu_src2),
        .rs1_data     (rs1_data),
        .imm          (imm),
        .sys          (sys),
        .illegal      (illegal)
    );

    rv_alu u_alu (
        .alu_op  (alu_op),
        .word_op (word_op),
        .src1    (alu_src1),
        .src2    (alu_src2),
        .result  (alu_result)
    );

endmodule

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
    import rv_isa_pkg::*;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        imem_ack = 1'b0;
    logic [31:0] imem_rdata = 32'h0;
    logic        imem_req;
    logic [63:0] imem_addr;
    logic        retire_valid;
    logic [63:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [63:0] retire_wdata;
    logic        retire_we;
    logic        halted;

    logic [31:0] prog [0:255];
    logic [63:0] xr [0:31];
    logic [63:0] pc_cursor;
    logic [63:0] ebreak_pc = 64'hffff_ffff_ffff_fff0;
    int          cur_test;
    int          n_inst = 0;
    int          cyc = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          test_err [1:6];
    string       test_name [1:6];
    logic [1:0]  wait_cnt;
    int          sb_id;

    logic [63:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [63:0] exp_val [$];
    logic        exp_we [$];
    int          exp_test [$];

    rv_core u_dut (
        .clk          (clk),
        .rst          (rst),
        .imem_ack     (imem_ack),
        .imem_rdata   (imem_rdata),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .retire_we    (retire_we),
        .halted       (halted)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {imm12, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm20, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {imm20, rd, op};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    function automatic logic [63:0] sign_extend_word(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // store one instruction and its expected retire entry
    task automatic add_inst(input logic [31:0] word, input logic [4:0] rd,
                            input logic [63:0] val, input logic we);
        prog[pc_cursor[9:2]] = word;
        exp_pc.push_back(pc_cursor);
        exp_rd.push_back(rd);
        exp_val.push_back(val);
        exp_we.push_back(we && (rd != 5'd0));
        exp_test.push_back(cur_test);
        if (we && (rd != 5'd0)) begin
            xr[rd] = val;
        end
        pc_cursor = pc_cursor + 64'd4;
    endtask

    // offset 8, a taken branch skips one slot
    task automatic add_branch(input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic taken);
        add_inst(encode_b(13'd8, rs2, rs1, f3), 5'd0, 64'd0, 1'b0);
        if (taken) begin
            pc_cursor = pc_cursor + 64'd4;
        end
    endtask

    task automatic build_program();
        logic [63:0] t;
        for (int i = 0; i < 256; i++) begin
            // opcode 7f is illegal, a stray fetch halts the core
            prog[i] = {i[24:0], 7'h7f};
        end
        for (int i = 0; i < 32; i++) begin
            xr[i] = 64'd0;
        end
        pc_cursor = reset_pc;
        cur_test = 1;
        add_inst(encode_i(12'd100, 0, 3'b000, 1, op_imm), 1, 64'd100, 1);
        add_inst(encode_i(12'hff9, 0, 3'b000, 2, op_imm), 2, -64'd7, 1);
        add_inst(encode_r(7'h00, 2, 1, 3'b000, 3, op_reg), 3, xr[1] + xr[2], 1);
        add_inst(encode_r(7'h20, 1, 2, 3'b000, 4, op_reg), 4, xr[2] - xr[1], 1);
        add_inst(encode_i(12'd40, 1, 3'b001, 5, op_imm), 5, xr[1] << 40, 1);
        add_inst(encode_i(12'd60, 2, 3'b101, 6, op_imm), 6, xr[2] >> 60, 1);
        add_inst(encode_i(12'h402, 2, 3'b101, 7, op_imm), 7, $signed(xr[2]) >>> 2, 1);
        add_inst(encode_r(7'h00, 6, 1, 3'b001, 8, op_reg), 8, xr[1] << xr[6][5:0], 1);
        add_inst(encode_r(7'h00, 6, 2, 3'b101, 9, op_reg), 9, xr[2] >> xr[6][5:0], 1);
        add_inst(encode_r(7'h20, 6, 2, 3'b101, 10, op_reg), 10,
                 $signed(xr[2]) >>> xr[6][5:0], 1);
        add_inst(encode_r(7'h00, 1, 2, 3'b010, 11, op_reg), 11,
                 {63'd0, $signed(xr[2]) < $signed(xr[1])}, 1);
        add_inst(encode_r(7'h00, 1, 2, 3'b011, 12, op_reg), 12, {63'd0, xr[2] < xr[1]}, 1);
        add_inst(encode_i(12'hffa, 2, 3'b010, 13, op_imm), 13,
                 {63'd0, $signed(xr[2]) < -64'sd6}, 1);
        add_inst(encode_i(12'd101, 1, 3'b011, 14, op_imm), 14, {63'd0, xr[1] < 64'd101}, 1);
        add_inst(encode_r(7'h00, 2, 1, 3'b100, 15, op_reg), 15, xr[1] ^ xr[2], 1);
        add_inst(encode_r(7'h00, 2, 1, 3'b110, 16, op_reg), 16, xr[1] | xr[2], 1);
        add_inst(encode_r(7'h00, 2, 1, 3'b111, 17, op_reg), 17, xr[1] & xr[2], 1);
        add_inst(encode_i(12'h0f0, 1, 3'b100, 18, op_imm), 18, xr[1] ^ 64'h0f0, 1);
        add_inst(encode_u(20'h7ffff, 19, op_lui), 19, sign_extend_word({20'h7ffff, 12'h0}), 1);
        // word results with bit 31 set must come out negative
        add_inst(encode_r(7'h00, 19, 19, 3'b000, 20, op_reg_32), 20,
                 sign_extend_word(xr[19][31:0] + xr[19][31:0]), 1);
        add_inst(encode_i(12'd25, 1, 3'b001, 21, op_imm_32), 21,
                 sign_extend_word(xr[1][31:0] << 25), 1);
        add_inst(encode_r(7'h20, 1, 2, 3'b000, 22, op_reg_32), 22,
                 sign_extend_word(xr[2][31:0] - xr[1][31:0]), 1);
        cur_test = 2;
        add_inst(encode_i(12'd55, 1, 3'b000, 0, op_imm), 0, xr[1] + 64'd55, 1);
        add_inst(encode_r(7'h00, 1, 0, 3'b000, 23, op_reg), 23, xr[0] + xr[1], 1);
        cur_test = 3;
        // x1 = 100, x2 = -7
        add_branch(f3_beq, 1, 1, 1'b1);
        add_branch(f3_beq, 1, 2, 1'b0);
        add_branch(f3_bne, 1, 2, 1'b1);
        add_branch(f3_bne, 1, 1, 1'b0);
        add_branch(f3_blt, 2, 1, 1'b1);
        add_branch(f3_blt, 1, 2, 1'b0);
        add_branch(f3_bge, 1, 2, 1'b1);
        add_branch(f3_bge, 2, 1, 1'b0);
        add_branch(f3_bltu, 1, 2, 1'b1);
        add_branch(f3_bltu, 2, 1, 1'b0);
        add_branch(f3_bgeu, 2, 1, 1'b1);
        add_branch(f3_bgeu, 1, 2, 1'b0);
        cur_test = 4;
        add_inst(encode_u(20'h80001, 24, op_lui), 24, sign_extend_word({20'h80001, 12'h0}), 1);
        add_inst(encode_u(20'h00012, 25, op_auipc), 25,
                 pc_cursor + sign_extend_word({20'h00012, 12'h0}), 1);
        add_inst(encode_j(21'd12, 26), 26, pc_cursor + 64'd4, 1);
        pc_cursor = pc_cursor + 64'd8;
        // jalr target sum is odd, bit 0 must be cleared
        t = pc_cursor + 64'd16;
        add_inst(encode_i(t[11:0] - 12'd3, 0, 3'b000, 28, op_imm), 28, t - 64'd3, 1);
        add_inst(encode_i(12'd4, 28, 3'b000, 27, op_jalr), 27, pc_cursor + 64'd4, 1);
        pc_cursor = t;
        add_inst(encode_r(7'h00, 26, 27, 3'b000, 29, op_reg), 29, xr[27] + xr[26], 1);
        ebreak_pc = pc_cursor;
        add_inst(inst_ebreak, 0, 64'd0, 0);
        n_inst = exp_pc.size();
    endtask

    task automatic record_failure(input int id, input string msg);
        fail_cnt++;
        test_err[id]++;
        $display("%s", msg);
    endtask

    task automatic compare_field(input int id, input string name, input logic [63:0] expv,
                                 input logic [63:0] act);
        assert (expv === act) pass_cnt++;
        else record_failure(id, $sformatf("ERROR %s: expected %h, got %h", name, expv, act));
    endtask

    task automatic report_test(input int id);
        $display("test %0d %s: %s", id, test_name[id], (test_err[id] == 0) ? "pass" : "fail");
    endtask

    // instruction memory, random ack latency
    initial begin
        void'($urandom(32'h881e_d8c6));
        forever begin
            @(posedge clk);
            if (rst) begin
                imem_ack <= 1'b0;
                wait_cnt <= 2'($urandom_range(3, 0));
            end else if (imem_req && !imem_ack) begin
                if (wait_cnt == 2'd0) begin
                    imem_rdata <= prog[imem_addr[9:2]];
                    imem_ack   <= 1'b1;
                    wait_cnt   <= 2'($urandom_range(3, 0));
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else if (!imem_req && imem_ack) begin
                if (wait_cnt == 2'd0) begin
                    imem_ack <= 1'b0;
                    wait_cnt <= 2'($urandom_range(3, 0));
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

    // retire scoreboard, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            if (exp_pc.size() == 0) begin
                record_failure(6, $sformatf("unexpected retire at pc %h after the program",
                                            retire_pc));
            end else begin
                sb_id = exp_test.pop_front();
                compare_field(sb_id, "retire_pc", exp_pc.pop_front(), retire_pc);
                compare_field(sb_id, "retire_we", 64'(exp_we[0]), 64'(retire_we));
                if (exp_we[0]) begin
                    compare_field(sb_id, "retire_rd", 64'(exp_rd[0]), 64'(retire_rd));
                    compare_field(sb_id, "retire_wdata", exp_val[0], retire_wdata);
                end
                void'(exp_we.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_val.pop_front());
                if (exp_test.size() == 0 || exp_test[0] != sb_id) begin
                    report_test(sb_id);
                end
            end
        end
    end

    a_req_in_reset: assert property (@(posedge clk) (rst && cyc > 1) |-> !imem_req)
        pass_cnt++;
    else
        record_failure(5, "imem_req was high during reset");

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
                                 (imem_req && !imem_ack) |=> imem_req)
        pass_cnt++;
    else
        record_failure(5, "imem_req dropped before the memory acknowledged");

    a_req_wait_ack_low: assert property (@(posedge clk) disable iff (rst)
                                         (!imem_req && imem_ack) |=> !imem_req)
        pass_cnt++;
    else
        record_failure(5, "imem_req raised while imem_ack was still high");

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
                                    imem_req |=> (!imem_req || $stable(imem_addr)))
        pass_cnt++;
    else
        record_failure(5, "imem_addr changed while imem_req was high");

    a_halt_after_ebreak: assert property (@(posedge clk) disable iff (rst)
                                          (retire_valid && retire_pc == ebreak_pc) |=> halted)
        pass_cnt++;
    else
        record_failure(6, "halted did not rise after the ebreak retired");

    a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
                                    halted |=> (halted && !imem_req))
        pass_cnt++;
    else
        record_failure(6, "core left halt or issued a fetch while halted");

    // watchdog
    initial begin
        wait (n_inst > 0);
        repeat (n_inst * 20) @(posedge clk);
        $display("watchdog timeout, the core did not halt within %0d cycles", n_inst * 20);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        test_name[1] = "arithmetic";
        test_name[2] = "x0";
        test_name[3] = "branches";
        test_name[4] = "jumps and upper immediates";
        test_name[5] = "handshake";
        test_name[6] = "halt";
        for (int i = 1; i <= 6; i++) begin
            test_err[i] = 0;
        end
        build_program();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        while (!halted) begin
            @(posedge clk);
        end
        repeat (50) @(posedge clk);
        assert (exp_pc.size() == 0) pass_cnt++;
        else record_failure(6, $sformatf("core halted with %0d instructions not retired",
                                         exp_pc.size()));
        report_test(5);
        report_test(6);
        $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/rv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/rv_control.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_alu.sv
design/rv_fetch.sv
design/rv_core.sv
sim/tb_rv_core.sv
